// ==== logic/progress_pkg.sv ====
// Progress controller package with microcode control, shift status and bus request types
package progress_pkg;

   // Bus address word and byte-select vector
   typedef logic [31:0] addr_t;
   typedef logic [3:0]  sel_t;

   // Microcode control bits for the current step, 12 bits in all
   typedef struct packed {
      logic [3:0] wr_sel;      // RAM write-address select
      logic       latch_sel;   // Latch byte selects
      logic       q_en;        // Part of Q-register enable
      logic       read_in;     // Read the input
      logic       repeat_shr;  // Repeat shift right until it completes
      logic       bus_start;   // May start a strobe
      logic       bus_write;   // May start a write
      logic       write_hold;  // Write enables clear when low
      logic       word_store;  // Word store, must be word aligned
   } ucode_ctrl_t;

   // Shift status from the shifter
   typedef struct packed {
      logic last_shift;        // Final step of a shift
      logic reg_last_shift;    // Registered copy, inhibits the RAM write
   } shift_stat_t;

   // Bus request outputs
   typedef struct packed {
      logic stb_io;            // I/O strobe
      logic stb_sram;          // SRAM strobe
      logic we;                // Write enable to SRAM or I/O
      logic ctrlreg_we;        // Control-register write enable
   } bus_req_t;

   // Write-select codes that shape the byte selects
   localparam logic [3:0] WRSEL_HALF = 4'b0001;  // Halfword store
   localparam logic [3:0] WRSEL_BYTE = 4'b0010;  // Byte store

   // Address regions, matched against the top address bits
   localparam logic       REGION_SRAM = 1'b1;     // addr[31]
   localparam logic [1:0] REGION_IO   = 2'b01;    // addr[31:30]
   localparam logic [3:0] REGION_CTRL = 4'b0010;  // addr[31:28]

   // Anything not matched above is neither memory nor I/O
   // The control-register region overlaps neither of the other two

endpackage

// ==== logic/byte_select.sv ====
// Byte select decoder, latches the byte selects and the active-low RAM byte mask
`timescale 1ns/1ps

module byte_select (
   input  logic                      clk,
   input  logic                      RST_I,
   input  progress_pkg::ucode_ctrl_t ctrl,     // Microcode control for this step
   input  logic [1:0]                addr_lo,  // Byte offset within the word
   output progress_pkg::sel_t        sel_o,    // Byte selects to SRAM and I/O
   output progress_pkg::sel_t        bmask     // Same selects, active low, for on-chip RAM
);

   import progress_pkg::*;

   sel_t sel_d;  // Decoded select, before the latch

   // Decode write-select code and byte offset
   always_comb begin
      case (ctrl.wr_sel)
         WRSEL_HALF: begin
            case (addr_lo)
               2'd0:    sel_d = 4'b0011;  // Lower halfword
               2'd2:    sel_d = 4'b1100;  // Upper halfword
               default: sel_d = 4'b1111;  // Odd halfword offset, treat as word
            endcase
         end
         WRSEL_BYTE: begin
            sel_d = 4'b0001 << addr_lo;   // One-hot at byte offset
         end
         default: begin
            sel_d = 4'b1111;              // Full word
         end
      endcase
   end

   // Latch select and its inverse together
   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel_o <= 4'h0;
         bmask <= 4'hf;                   // All bytes masked after reset
      end else if (ctrl.latch_sel) begin
         sel_o <= sel_d;
         bmask <= ~sel_d;
      end
   end

   // RAM mask must always mirror the bus byte selects
   a_sel_mask_inverse: assert property (
      @(posedge clk) disable iff (RST_I)
      sel_o == ~bmask
   ) else $error("byte_select: sel_o and bmask out of step");

endmodule

// ==== logic/bus_request.sv ====
// Bus request block, drives the I/O and SRAM strobes and the write enables
`timescale 1ns/1ps

module bus_request #(
   parameter bit SRAM_PRESENT    = 1'b1,  // SRAM strobe stays low when 0
   parameter bit CTRLREG_PRESENT = 1'b1   // Control-register write enable stays low when 0
) (
   input  logic                      clk,
   input  logic                      RST_I,
   input  logic                      core_running,  // Core out of reset and executing
   input  progress_pkg::ucode_ctrl_t ctrl,          // Microcode control for this step
   input  progress_pkg::addr_t       addr,          // Bus address
   input  logic                      bus_error,     // Aborts the current access
   input  logic                      qack,          // Qualified I/O acknowledge
   input  logic                      sram_ack,      // SRAM acknowledge
   output progress_pkg::bus_req_t    req            // Strobes and write enables
);

   import progress_pkg::*;

   logic bad_align;       // Access must not reach the bus
   logic in_sram;         // Address decodes to SRAM
   logic in_io;           // Address decodes to I/O
   logic in_ctrl;         // Address decodes to control registers
   logic stb_io_q;
   logic stb_sram_q;
   logic we_q;
   logic ctrlreg_we_q;
   logic stb_io_d;
   logic stb_sram_d;
   logic we_d;
   logic ctrlreg_we_d;
   logic we_clr;          // Clear both write enables

   // Not running, or a word store off a word boundary
   assign bad_align = ~core_running | (ctrl.word_store & (|addr[1:0]));

   // Region decode from the top address bits
   assign in_sram = (addr[31] == REGION_SRAM);
   assign in_io   = (addr[31:30] == REGION_IO);
   assign in_ctrl = (addr[31:28] == REGION_CTRL);

   // Set on a start into the region, hold until acknowledged
   assign stb_io_d   = (ctrl.bus_start & in_io & ~bad_align) | (stb_io_q & ~qack);
   assign stb_sram_d = SRAM_PRESENT
                     & ((ctrl.bus_start & in_sram & ~bad_align) | (stb_sram_q & ~sram_ack));

   // A control-register write is also a bus write
   assign ctrlreg_we_d = CTRLREG_PRESENT & in_ctrl & ~bad_align;
   assign we_d         = ((in_sram | in_io) & ~bad_align) | ctrlreg_we_d;
   assign we_clr       = RST_I | bus_error | ~ctrl.write_hold;

   // Strobe registers
   always_ff @(posedge clk) begin
      if (RST_I || bus_error) begin
         stb_io_q   <= 1'b0;   // Error abandons the access
         stb_sram_q <= 1'b0;
      end else begin
         stb_io_q   <= stb_io_d;
         stb_sram_q <= stb_sram_d;
      end
   end

   // Write-enable registers
   always_ff @(posedge clk) begin
      if (we_clr) begin
         we_q         <= 1'b0;
         ctrlreg_we_q <= 1'b0;
      end else if (ctrl.bus_write) begin  // bus_error already covered by we_clr
         we_q         <= we_d;
         ctrlreg_we_q <= ctrlreg_we_d;
      end
   end

   assign req = '{
      stb_io:     stb_io_q,
      stb_sram:   stb_sram_q,
      we:         we_q,
      ctrlreg_we: ctrlreg_we_q
   };

   // Only one access can be in flight
   a_one_strobe: assert property (
      @(posedge clk) disable iff (RST_I)
      !(req.stb_io && req.stb_sram)
   ) else $error("bus_request: I/O and SRAM strobes high together");

   // Control-register write rides on a normal write
   a_ctrlreg_we: assert property (
      @(posedge clk) disable iff (RST_I)
      req.ctrlreg_we |-> req.we
   ) else $error("bus_request: ctrlreg_we without we");

endmodule

// ==== logic/ack_qualifier.sv ====
// Acknowledge qualifier that tolerates a slave holding its acknowledge high
`timescale 1ns/1ps

module ack_qualifier #(
   parameter bit ACK_HELD_RULE   = 1'b1,  // Use the held-acknowledge machine
   parameter bit CTRLREG_PRESENT = 1'b1   // Honour the system-register acknowledge
) (
   input  logic clk,
   input  logic RST_I,
   input  logic ack_i,       // Acknowledge from the I/O slave
   input  logic sysreg_ack,  // Acknowledge from the system registers
   input  logic stb_io,      // Current I/O strobe
   output logic qack         // Qualified acknowledge
);

   logic sys_ack;  // System-register acknowledge, if present

   assign sys_ack = CTRLREG_PRESENT & sysreg_ack;

   generate
      if (ACK_HELD_RULE) begin : g_held
         logic held;      // Slave seen holding ack without a strobe
         logic held_d;

         /*
          * An ack without a strobe means the slave keeps ack asserted
          * all the time. In that state the strobe itself stands in for
          * the ack. Once ack drops we trust the slave again.
          *
          *   state   ack_i stb_io   next
          *   normal    1     0      held
          *   normal    x     x      normal otherwise
          *   held      1     x      held
          *   held      0     x      normal
          */
         assign held_d = ack_i & (held | ~stb_io);

         always_ff @(posedge clk) begin
            if (RST_I) begin
               held <= 1'b0;
            end else begin
               held <= held_d;
            end
         end

         // Held state follows the strobe and normal state needs both
         always_comb begin
            if (sys_ack) begin
               qack = 1'b1;
            end else if (held) begin
               qack = stb_io;
            end else begin
               qack = ack_i & stb_io;
            end
         end
      end else begin : g_plain
         assign qack = ack_i | sys_ack;  // Plain OR of the acknowledges
      end
   endgenerate

endmodule

// ==== logic/ucode_progress.sv ====
// Microcode progress logic, gates the sequencer, the Q register and the RAM write
`timescale 1ns/1ps

module ucode_progress (
   input  logic                      core_running,   // Core executing
   input  progress_pkg::ucode_ctrl_t ctrl,           // Microcode control for this step
   input  progress_pkg::shift_stat_t shift,          // Shift completion status
   input  progress_pkg::bus_req_t    req,            // Current bus request
   input  logic                      bus_error,      // Bus error, forces progress
   output logic                      progress_ucode, // Sequencer may advance
   output logic                      ena_q,          // Q register loads
   output logic                      iwe             // On-chip RAM write enable
);

   logic stb_pending;   // A strobe waits for its acknowledge
   logic shift_done;    // Either no repeat requested or the shift has ended
   logic q_request;     // Microcode asks for a Q update
   logic iwe_block;     // Conditions that keep the RAM from writing

   assign stb_pending = req.stb_io | req.stb_sram;

   // Repeated shift-right holds the step until the last shift
   assign shift_done = ~ctrl.repeat_shr | shift.last_shift | shift.reg_last_shift;

   // Advance when nothing waits, always on an error so the trap code runs
   assign progress_ucode = (shift_done & ~stb_pending) | bus_error;

   /*
    * Q codes from the microcode
    *   read_in q_en
    *      0     0    hold
    *      0     1    shift, load, clear
    *      1     x    sample input
    * Q is frozen on the last shift and while the bus is busy
    */
   assign q_request = ctrl.q_en | ctrl.read_in;
   assign ena_q     = q_request & ~shift.last_shift & ~stb_pending;

   /*
    * RAM writes are the default, except
    *   latch_sel        step only sets up the byte selects
    *   req.we           data goes to SRAM or I/O instead
    *   reg_last_shift   shift result must not be stored
    * Qualified with core_running so nothing is written before start
    */
   assign iwe_block = ctrl.latch_sel | req.we | shift.reg_last_shift;
   assign iwe       = core_running & ~iwe_block;

endmodule

// ==== logic/progress_ctrl.sv ====
// Progress controller top level, joins byte selects, bus requests, ack qualifier and ucode gating
`timescale 1ns/1ps

module progress_ctrl #(
   parameter bit SRAM_PRESENT    = 1'b1,  // SRAM attached
   parameter bit CTRLREG_PRESENT = 1'b1,  // Control registers attached
   parameter bit ACK_HELD_RULE   = 1'b1   // Tolerate a held acknowledge
) (
   input  logic                      clk,
   input  logic                      RST_I,
   input  logic                      core_running,   // Core executing
   input  progress_pkg::ucode_ctrl_t ctrl,           // Microcode control for this step
   input  progress_pkg::shift_stat_t shift,          // Shifter status
   input  progress_pkg::addr_t       addr,           // Bus address
   input  logic                      bus_error,      // Bus error
   input  logic                      ack_i,          // I/O acknowledge
   input  logic                      sysreg_ack,     // System-register acknowledge
   input  logic                      sram_ack,       // SRAM acknowledge
   output progress_pkg::sel_t        sel_o,          // Byte selects
   output progress_pkg::sel_t        bmask,          // Active-low RAM byte mask
   output progress_pkg::bus_req_t    req,            // Strobes and write enables
   output logic                      qack,           // Qualified acknowledge
   output logic                      progress_ucode, // Sequencer advance
   output logic                      ena_q,          // Q register enable
   output logic                      iwe             // On-chip RAM write enable
);

   // Byte selects latched from the low address bits
   byte_select u_byte_select (
      .clk     (clk),
      .RST_I   (RST_I),
      .ctrl    (ctrl),
      .addr_lo (addr[1:0]),
      .sel_o   (sel_o),
      .bmask   (bmask)
   );

   // Strobes and write enables
   bus_request #(
      .SRAM_PRESENT    (SRAM_PRESENT),
      .CTRLREG_PRESENT (CTRLREG_PRESENT)
   ) u_bus_request (
      .clk          (clk),
      .RST_I        (RST_I),
      .core_running (core_running),
      .ctrl         (ctrl),
      .addr         (addr),
      .bus_error    (bus_error),
      .qack         (qack),        // Ends the I/O strobe
      .sram_ack     (sram_ack),
      .req          (req)
   );

   // Acknowledge cleanup for the I/O side
   ack_qualifier #(
      .ACK_HELD_RULE   (ACK_HELD_RULE),
      .CTRLREG_PRESENT (CTRLREG_PRESENT)
   ) u_ack_qualifier (
      .clk        (clk),
      .RST_I      (RST_I),
      .ack_i      (ack_i),
      .sysreg_ack (sysreg_ack),
      .stb_io     (req.stb_io),
      .qack       (qack)
   );

   // Sequencer, Q and RAM write gating
   ucode_progress u_ucode_progress (
      .core_running   (core_running),
      .ctrl           (ctrl),
      .shift          (shift),
      .req            (req),
      .bus_error      (bus_error),
      .progress_ucode (progress_ucode),
      .ena_q          (ena_q),
      .iwe            (iwe)
   );

endmodule

// ==== tb/progress_tests.svh ====
// Directed tests for the progress controller with one task per behavior
`ifndef PROGRESS_TESTS_SVH
`define PROGRESS_TESTS_SVH

// Expected byte select from write-select code and byte offset
function automatic sel_t expected_sel(input logic [3:0] code, input logic [1:0] offset);
   if (code == WRSEL_HALF && offset == 2'd0) return 4'h3;
   if (code == WRSEL_HALF && offset == 2'd2) return 4'hc;
   if (code == WRSEL_BYTE) begin
      case (offset)
         2'd0:    return 4'h1;
         2'd1:    return 4'h2;
         2'd2:    return 4'h4;
         default: return 4'h8;
      endcase
   end
   return 4'hf;                                  // Full word
endfunction

// Expected {progress_ucode, ena_q, iwe}
function automatic logic [2:0] expected_gating(input logic running, input ucode_ctrl_t c,
      input shift_stat_t s, input logic pending, input logic we, input logic err);
   logic prog;
   logic q;
   logic w;
   prog = err ? 1'b1
        : pending ? 1'b0
        : (!c.repeat_shr || s.last_shift || s.reg_last_shift);
   q = (c.q_en || c.read_in) && !s.last_shift && !pending;
   w = running && !c.latch_sel && !we && !s.reg_last_shift;
   return {prog, q, w};
endfunction

// Random word-aligned address with the top 1, 2 or 4 bits taken from prefix
task automatic random_addr(input logic [3:0] prefix, input int width, output addr_t a);
   logic [31:0] bits;
   take_bits(30, bits);
   a = {bits[29:0], 2'b00};
   case (width)
      1:       a[31]    = prefix[0];
      2:       a[31:30] = prefix[1:0];
      default: a[31:28] = prefix;
   endcase
endtask

// Starts an aligned or misaligned word store into I/O or SRAM
task automatic start_access(input logic to_sram, input logic misalign);
   addr_t a;
   random_addr(4'b0001, to_sram ? 1 : 2, a);
   if (misalign) a[1:0] = 2'b10;
   addr            = a;
   ctrl.bus_start  = 1'b1;
   ctrl.word_store = 1'b1;
endtask

task automatic drop_start();
   ctrl.bus_start  = 1'b0;
   ctrl.word_store = 1'b0;
endtask

task automatic test_byte_selects();
   logic [3:0] codes [4];
   int         c;
   int         o;
   codes = '{WRSEL_HALF, WRSEL_BYTE, 4'b0000, 4'b0111};
   check_sel("sel_o", sel_o, 4'h0);              // Reset values
   check_sel("bmask", bmask, 4'hf);
   for (c = 0; c < 4; c++) begin
      for (o = 0; o < 4; o++) begin
         ctrl.wr_sel    = codes[c];
         ctrl.latch_sel = 1'b1;
         addr           = {30'h0, o[1:0]};
         step();
         ctrl.latch_sel = 1'b0;
         check_sel("sel_o", sel_o, expected_sel(codes[c], o[1:0]));
         check_sel("bmask", bmask, ~expected_sel(codes[c], o[1:0]));
      end
   end
   ctrl.wr_sel = WRSEL_HALF;                     // Would give 3 if latched
   addr        = '0;
   step();
   check_sel("sel_o", sel_o, 4'hf);              // Holds without latch_sel
   ctrl.wr_sel = 4'h0;
endtask

// Start, random wait, ack, misaligned store and error abort
task automatic test_strobe(input logic to_sram);
   bus_req_t    pend;
   logic [31:0] hold;
   int          i;
   pend = to_sram ? SRAM_PENDING : IO_PENDING;
   start_access(to_sram, 1'b0);
   step();
   drop_start();
   check_req("req", req, pend);                  // Rose one cycle after start
   take_bits(3, hold);
   for (i = 0; i <= hold; i++) begin
      step();
      check_req("req", req, pend);               // Waits for its ack
   end
   if (to_sram) sram_ack = 1'b1;
   else ack_i = 1'b1;
   step();
   sram_ack = 1'b0;
   ack_i    = 1'b0;
   check_req("req", req, '0);
   start_access(to_sram, 1'b1);                  // Misaligned word store
   step();
   drop_start();
   check_req("req", req, '0);
   start_access(to_sram, 1'b0);
   step();
   drop_start();
   check_req("req", req, pend);
   bus_error = 1'b1;                             // Abandons the access
   step();
   bus_error = 1'b0;
   check_req("req", req, '0);
endtask

// One bus_write into a region that write_hold then clears
task automatic write_case(input logic [3:0] prefix, input int width,
                          input logic exp_we, input logic exp_cwe);
   addr_t    a;
   bus_req_t exp;
   random_addr(prefix, width, a);
   exp            = '0;
   exp.we         = exp_we;
   exp.ctrlreg_we = exp_cwe;
   addr           = a;
   ctrl.bus_write = 1'b1;
   step();
   ctrl.bus_write = 1'b0;
   check_req("req", req, exp);
   step();
   check_req("req", req, exp);                   // Kept while write_hold is high
   ctrl.write_hold = 1'b0;
   step();
   ctrl.write_hold = 1'b1;
   check_req("req", req, '0);
endtask

task automatic test_write_enables();
   write_case(4'b0001, 1, 1'b1, 1'b0);           // SRAM
   write_case(4'b0010, 4, 1'b1, 1'b1);           // Control registers
   write_case(4'b0011, 4, 1'b0, 1'b0);           // Neither region
   write_case(4'b0001, 2, 1'b1, 1'b0);           // I/O
endtask

task automatic test_ack_qualifier();
   ack_i = 1'b1;                                 // Ack with no strobe
   settle();
   check_bit("qack", qack, 1'b0);
   step();
   start_access(1'b0, 1'b0);
   settle();
   check_bit("qack", qack, 1'b0);                // Held state with the strobe still low
   step();
   check_bit("qack", qack, 1'b1);                // Held state follows the strobe
   drop_start();
   step();
   check_req("req", req, '0);
   check_bit("qack", qack, 1'b0);
   sysreg_ack = 1'b1;
   settle();
   check_bit("qack", qack, 1'b1);
   sysreg_ack = 1'b0;
   ack_i      = 1'b0;                            // Back to normal at next edge
   step();
   start_access(1'b0, 1'b0);
   step();
   check_req("req", req, IO_PENDING);
   check_bit("qack", qack, 1'b0);                // Strobe alone is no ack when normal
   drop_start();
   sysreg_ack = 1'b1;
   settle();
   check_bit("qack", qack, 1'b1);
   step();
   check_req("req", req, '0);
   sysreg_ack = 1'b0;
endtask

// Drives one gating vector and checks the three outputs
task automatic apply_gating(input logic [7:0] v, input logic pending, input logic we);
   logic [2:0] exp;
   core_running         = v[7];
   ctrl.repeat_shr      = v[6];
   ctrl.q_en            = v[5];
   ctrl.read_in         = v[4];
   ctrl.latch_sel       = v[3];
   shift.last_shift     = v[2];
   shift.reg_last_shift = v[1];
   bus_error            = v[0];
   settle();
   exp = expected_gating(core_running, ctrl, shift, pending, we, bus_error);
   check_bit("progress_ucode", progress_ucode, exp[2]);
   check_bit("ena_q", ena_q, exp[1]);
   check_bit("iwe", iwe, exp[0]);
   step();
endtask

task automatic test_gating();
   int v;
   for (v = 0; v < 256; v++) begin
      apply_gating(v[7:0], 1'b0, 1'b0);          // All combinations with nothing pending
   end
   apply_gating(8'h80, 1'b0, 1'b0);              // Running and otherwise quiet
   start_access(1'b0, 1'b0);
   step();
   drop_start();
   check_req("req", req, IO_PENDING);
   for (v = 0; v < 64; v++) begin
      apply_gating({1'b1, v[5:0], 1'b0}, 1'b1, 1'b0);
   end
   check_req("req", req, IO_PENDING);
   apply_gating(8'ha1, 1'b1, 1'b0);              // Error forces progress and ends the strobe
   bus_error = 1'b0;
   check_req("req", req, '0);
   start_access(1'b1, 1'b0);                     // SRAM strobe holds the step as well
   step();
   drop_start();
   check_req("req", req, SRAM_PENDING);
   apply_gating(8'hb0, 1'b1, 1'b0);
   sram_ack = 1'b1;
   apply_gating(8'hb0, 1'b1, 1'b0);              // Still pending until the edge
   sram_ack = 1'b0;
   check_req("req", req, '0);
   random_addr(4'b0001, 1, addr);
   ctrl.bus_write = 1'b1;
   step();
   ctrl.bus_write = 1'b0;
   check_req("req", req, '{we: 1'b1, default: 1'b0});
   apply_gating(8'h80, 1'b0, 1'b1);              // we blocks the RAM write
   ctrl.write_hold = 1'b0;
   step();
   ctrl.write_hold = 1'b1;
endtask

`endif

// ==== tb/tb_progress_ctrl.sv ====
// Testbench for the progress controller, runs the directed tests and reports the result
`timescale 1ns/1ps

module tb_progress_ctrl;

   import progress_pkg::*;

   localparam int CYCLE_LIMIT = 2000;  // About four times the full test length
   localparam bus_req_t IO_PENDING   = '{stb_io: 1'b1, default: 1'b0};
   localparam bus_req_t SRAM_PENDING = '{stb_sram: 1'b1, default: 1'b0};

   logic        clk = 1'b0;
   logic        RST_I;
   logic        core_running;
   ucode_ctrl_t ctrl;
   shift_stat_t shift;
   addr_t       addr;
   logic        bus_error;
   logic        ack_i;
   logic        sysreg_ack;
   logic        sram_ack;
   sel_t        sel_o;
   sel_t        bmask;
   bus_req_t    req;
   logic        qack;
   logic        progress_ucode;
   logic        ena_q;
   logic        iwe;

   int          sel_errors;    // Failed checks per result kind
   int          req_errors;
   int          bit_errors;
   int          cycle_count;
   logic [15:0] lfsr;          // Address randomness

   progress_ctrl #(
      .SRAM_PRESENT    (1'b1),
      .CTRLREG_PRESENT (1'b1),
      .ACK_HELD_RULE   (1'b1)
   ) u_progress_ctrl (.*);

   always begin
      #5 clk = ~clk;           // 10 ns period
   end

   // Guard against a stuck run
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // Inputs change only on the falling edge
   task automatic step();
      @(negedge clk);
   endtask

   // Lets combinational outputs follow freshly driven inputs
   task automatic settle();
      #1;
   endtask

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] bits);
      int i;
      bits = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[30:0], lfsr[0]};
      end
   endtask

   task automatic check_sel(input string name, input sel_t got, input sel_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
         sel_errors++;
      end
   endtask

   task automatic check_req(input string name, input bus_req_t got, input bus_req_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
         req_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
         bit_errors++;
      end
   endtask

   `include "progress_tests.svh"

   initial begin
      sel_errors   = 0;
      req_errors   = 0;
      bit_errors   = 0;
      cycle_count  = 0;
      lfsr         = 16'd60;        // Seed
      RST_I        = 1'b1;
      core_running = 1'b0;
      ctrl         = '0;
      ctrl.write_hold = 1'b1;       // Keeps write enables loadable
      shift        = '0;
      addr         = '0;
      bus_error    = 1'b0;
      ack_i        = 1'b0;
      sysreg_ack   = 1'b0;
      sram_ack     = 1'b0;
      repeat (4) step();            // Reset over four rising edges
      RST_I        = 1'b0;
      core_running = 1'b1;
      test_byte_selects();
      test_strobe(1'b0);            // I/O
      test_strobe(1'b1);            // SRAM
      test_write_enables();
      test_ack_qualifier();
      test_gating();
      step();
      $display("Errors: sel %0d, req %0d, bit %0d", sel_errors, req_errors, bit_errors);
      if (sel_errors + req_errors + bit_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+tb
logic/progress_pkg.sv
logic/byte_select.sv
logic/bus_request.sv
logic/ack_qualifier.sv
logic/ucode_progress.sv
logic/progress_ctrl.sv
tb/tb_progress_ctrl.sv
